// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    localparam int ADDR_W     = 32;
    localparam int INST_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int LINE_W     = LINE_WORDS * INST_W;
    localparam int SETS       = 128;
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 7;
    localparam int OFFSET_W   = 5;
    localparam int WORD_W     = 3;   // word select inside a line
    localparam int WAYS       = 2;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INST_W-1:0]  inst_t;
    typedef logic [LINE_W-1:0]  line_t;  // word 0 in the low bits
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  uncache;
    } fetch_req_t;

    typedef struct packed {
        logic [1:0]  valid;  // bit 0 slot 0, bit 1 slot 1
        addr_t       pc;     // pc of slot 0
        inst_t [1:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        logic [WAYS-1:0] a_way;  // slot 0, per way
        logic [WAYS-1:0] b_way;  // slot 1, per way
    } hit_t;

    typedef struct packed {
        logic   en;
        logic   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

    typedef enum logic [2:0] {
        IDLE,
        ASKMEM1,
        ASKMEM2,
        RETURN,
        UNCACHE_RETURN
    } icache_state_e;

    function automatic tag_t tag_of(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t index_of(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [WORD_W-1:0] word_of(addr_t a);
        return a[OFFSET_W-1 -: WORD_W];
    endfunction

endpackage

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               pause,
    input  logic               branch_flush,
    input  fetch_req_t         fetch_req,
    input  hit_t               hit,
    input  logic               victim_way,
    input  logic               ret_valid,
    input  line_t              ret_data,
    input  logic               ucache_rvalid,
    input  inst_t              ucache_rdata,
    input  inst_t [1:0]        rd_inst,
    output logic               stall,
    output fetch_resp_t        fetch_resp,
    output logic               rd_req,
    output addr_t              rd_addr,
    output logic               ucache_ren,
    output addr_t              ucache_addr,
    output index_t             rd_index_a,
    output index_t             rd_index_b,
    output tag_t               lookup_tag_a,
    output tag_t               lookup_tag_b,
    output logic [WORD_W-1:0]  rd_word_a,
    output logic [WORD_W-1:0]  rd_word_b,
    output fill_t              fill,
    output logic [1:0]         touch_valid,
    output index_t             touch_index_a,
    output index_t             touch_index_b,
    output logic [1:0]         touch_way
);

    icache_state_e state, next_state;
    addr_t         pc_a, pc_b, live_b, fill_addr;
    logic          req_valid, req_uncache, same_line, b_miss_q;
    logic          mem_hold;
    inst_t         uc_word, uc_data;
    logic          take, lookup, a_hit, b_hit, got_ret, got_uc;
    fetch_resp_t   resp_q;

    assign live_b  = fetch_req.pc + ADDR_W'(4);
    assign take    = !stall && !pause;
    assign lookup  = state == IDLE && req_valid && !branch_flush;
    assign a_hit   = |hit.a_way;
    assign b_hit   = |hit.b_way;
    assign got_ret = ret_valid || mem_hold;      // pulse may have come during pause
    assign got_uc  = ucache_rvalid || mem_hold;
    assign uc_data = ucache_rvalid ? ucache_rdata : uc_word;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (lookup) begin
                    if (req_uncache) next_state = UNCACHE_RETURN;
                    else if (!a_hit) next_state = ASKMEM1;
                    else if (!b_hit) next_state = ASKMEM2;
                end
            end
            ASKMEM1: begin
                if (got_ret) begin
                    if (b_miss_q && req_valid && !branch_flush) next_state = ASKMEM2;
                    else next_state = RETURN;
                end
            end
            ASKMEM2: begin
                if (got_ret) next_state = RETURN;
            end
            RETURN: next_state = IDLE;  // arrays re-read with captured pcs
            UNCACHE_RETURN: begin
                if (got_uc) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // held through RETURN so the capture survives the re-read
    assign stall = (next_state != IDLE) || (state == RETURN);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (!pause) begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_hold <= 1'b0;
        end else if (!pause) begin
            mem_hold <= 1'b0;
        end else if ((rd_req && ret_valid) || (ucache_ren && ucache_rvalid)) begin
            mem_hold <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ucache_rvalid) uc_word <= ucache_rdata;
    end

    always_ff @(posedge clk) begin
        if (reset || branch_flush) begin
            req_valid <= 1'b0;
        end else if (take) begin
            req_valid <= fetch_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_a        <= fetch_req.pc;
            pc_b        <= live_b;
            req_uncache <= fetch_req.uncache;
            same_line   <= fetch_req.pc[ADDR_W-1:OFFSET_W] == live_b[ADDR_W-1:OFFSET_W];
        end
        if (state == IDLE && !pause) b_miss_q <= !b_hit && !same_line;
    end

    // array reads follow the live pc only when a request is taken
    assign rd_index_a   = take ? index_of(fetch_req.pc) : index_of(pc_a);
    assign rd_index_b   = take ? index_of(live_b) : index_of(pc_b);
    assign lookup_tag_a = tag_of(pc_a);
    assign lookup_tag_b = tag_of(pc_b);
    assign rd_word_a    = word_of(pc_a);
    assign rd_word_b    = word_of(pc_b);

    assign rd_req      = (state == ASKMEM1 || state == ASKMEM2) && !mem_hold;
    assign fill_addr   = state == ASKMEM1 ? pc_a : pc_b;
    assign rd_addr     = {fill_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign ucache_ren  = state == UNCACHE_RETURN && !mem_hold;
    assign ucache_addr = pc_a;

    always_comb begin
        fill.en    = ret_valid && (state == ASKMEM1 || state == ASKMEM2);
        fill.way   = victim_way;
        fill.index = index_of(fill_addr);
        fill.tag   = tag_of(fill_addr);
        fill.line  = ret_data;
    end

    assign touch_valid   = {b_hit, a_hit} & {2{lookup && !req_uncache && !pause}};
    assign touch_way     = {hit.b_way[1], hit.a_way[1]};
    assign touch_index_a = index_of(pc_a);
    assign touch_index_b = index_of(pc_b);

    always_ff @(posedge clk) begin
        if (reset || branch_flush) begin
            resp_q.valid <= 2'b00;
        end else if (!pause) begin
            resp_q.valid <= 2'b00;
            if (lookup && !req_uncache && a_hit && b_hit) begin
                resp_q.valid <= 2'b11;
                resp_q.pc    <= pc_a;
                resp_q.inst  <= rd_inst;
            end else if (state == UNCACHE_RETURN && got_uc && req_valid) begin
                resp_q.valid   <= 2'b01;  // slot 0 only
                resp_q.pc      <= pc_a;
                resp_q.inst[0] <= uc_data;
                resp_q.inst[1] <= '0;
            end
        end
    end

    assign fetch_resp = resp_q;

    // line side and uncached side never active together, returns included
    a_one_bus: assert property (@(posedge clk) disable iff (reset)
        !((rd_req || ret_valid) && (ucache_ren || ucache_rvalid)))
        else $error("line read and uncached read overlap");

    // a fill only answers a line read still outstanding
    a_fill_ret: assert property (@(posedge clk) disable iff (reset)
        $rose(fill.en) |-> ret_valid && rd_req)
        else $error("fill without line return");

endmodule

`default_nettype wire

// File: icache_tagv.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tagv
    import icache_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  index_t rd_index_a,
    input  index_t rd_index_b,
    input  tag_t   lookup_tag_a,
    input  tag_t   lookup_tag_b,
    input  fill_t  fill,
    output hit_t   hit
);

    tag_t            tag_mem [WAYS][SETS];
    logic [SETS-1:0] valid [WAYS];
    tag_t            tag_a_q [WAYS];
    tag_t            tag_b_q [WAYS];
    logic [WAYS-1:0] vld_a_q, vld_b_q;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill.en && fill.way == 1'(w)) tag_mem[w][fill.index] <= fill.tag;
            tag_a_q[w] <= tag_mem[w][rd_index_a];  // old tag on same-cycle write
            tag_b_q[w] <= tag_mem[w][rd_index_b];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            vld_a_q <= '0;
            vld_b_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (fill.en && fill.way == 1'(w)) valid[w][fill.index] <= 1'b1;
                vld_a_q[w] <= valid[w][rd_index_a];
                vld_b_q[w] <= valid[w][rd_index_b];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit.a_way[w] = vld_a_q[w] && (tag_a_q[w] == lookup_tag_a);
            hit.b_way[w] = vld_b_q[w] && (tag_b_q[w] == lookup_tag_b);
        end
    end

    // refills only go to a way after a miss, so a line lives in one way
    a_one_way: assert property (@(posedge clk) disable iff (reset)
        !(&hit.a_way) && !(&hit.b_way))
        else $error("line present in both ways");

endmodule

`default_nettype wire

// File: icache_data.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data
    import icache_pkg::*;
(
    input  logic              clk,
    input  index_t            rd_index_a,
    input  index_t            rd_index_b,
    input  logic [WORD_W-1:0] rd_word_a,
    input  logic [WORD_W-1:0] rd_word_b,
    input  hit_t              hit,
    input  fill_t             fill,
    output inst_t [1:0]       rd_inst
);

    inst_t bank_mem [WAYS][LINE_WORDS][SETS];
    inst_t rd_a_q [WAYS][LINE_WORDS];
    inst_t rd_b_q [WAYS][LINE_WORDS];

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int b = 0; b < LINE_WORDS; b++) begin
                if (fill.en && fill.way == 1'(w)) begin
                    bank_mem[w][b][fill.index] <= fill.line[b*INST_W +: INST_W];
                end
                rd_a_q[w][b] <= bank_mem[w][b][rd_index_a];  // port for slot 0
                rd_b_q[w][b] <= bank_mem[w][b][rd_index_b];  // port for slot 1
            end
        end
    end

    // way 0 unless way 1 hit
    assign rd_inst[0] = hit.a_way[1] ? rd_a_q[1][rd_word_a] : rd_a_q[0][rd_word_a];
    assign rd_inst[1] = hit.b_way[1] ? rd_b_q[1][rd_word_b] : rd_b_q[0][rd_word_b];

endmodule

`default_nettype wire

// File: icache_lru.sv
`timescale 1ns/1ns
`default_nettype none

module icache_lru
    import icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [1:0] touch_valid,
    input  index_t     touch_index_a,
    input  index_t     touch_index_b,
    input  logic [1:0] touch_way,
    input  fill_t      fill,
    output logic       victim_way
);

    logic [SETS-1:0] lru;  // way to replace next

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else begin
            if (touch_valid[0]) lru[touch_index_a] <= !touch_way[0];
            if (touch_valid[1]) lru[touch_index_b] <= !touch_way[1];
            if (fill.en) lru[fill.index] <= !fill.way;
        end
    end

    assign victim_way = lru[fill.index];

endmodule

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top
    import icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        pause,
    input  logic        branch_flush,
    input  fetch_req_t  fetch_req,
    output logic        stall,
    output fetch_resp_t fetch_resp,
    output logic        rd_req,
    output addr_t       rd_addr,
    input  logic        ret_valid,
    input  line_t       ret_data,
    output logic        ucache_ren,
    output addr_t       ucache_addr,
    input  logic        ucache_rvalid,
    input  inst_t       ucache_rdata
);

    hit_t              hit;
    fill_t             fill;
    logic              victim_way;
    inst_t [1:0]       rd_inst;
    index_t            rd_index_a, rd_index_b;
    tag_t              lookup_tag_a, lookup_tag_b;
    logic [WORD_W-1:0] rd_word_a, rd_word_b;
    logic [1:0]        touch_valid, touch_way;
    index_t            touch_index_a, touch_index_b;

    icache_ctrl ctrl_i (
        .clk           (clk),
        .reset         (reset),
        .pause         (pause),
        .branch_flush  (branch_flush),
        .fetch_req     (fetch_req),
        .hit           (hit),
        .victim_way    (victim_way),
        .ret_valid     (ret_valid),
        .ret_data      (ret_data),
        .ucache_rvalid (ucache_rvalid),
        .ucache_rdata  (ucache_rdata),
        .rd_inst       (rd_inst),
        .stall         (stall),
        .fetch_resp    (fetch_resp),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .ucache_ren    (ucache_ren),
        .ucache_addr   (ucache_addr),
        .rd_index_a    (rd_index_a),
        .rd_index_b    (rd_index_b),
        .lookup_tag_a  (lookup_tag_a),
        .lookup_tag_b  (lookup_tag_b),
        .rd_word_a     (rd_word_a),
        .rd_word_b     (rd_word_b),
        .fill          (fill),
        .touch_valid   (touch_valid),
        .touch_index_a (touch_index_a),
        .touch_index_b (touch_index_b),
        .touch_way     (touch_way)
    );

    icache_tagv tagv_i (
        .clk          (clk),
        .reset        (reset),
        .rd_index_a   (rd_index_a),
        .rd_index_b   (rd_index_b),
        .lookup_tag_a (lookup_tag_a),
        .lookup_tag_b (lookup_tag_b),
        .fill         (fill),
        .hit          (hit)
    );

    icache_data data_i (
        .clk        (clk),
        .rd_index_a (rd_index_a),
        .rd_index_b (rd_index_b),
        .rd_word_a  (rd_word_a),
        .rd_word_b  (rd_word_b),
        .hit        (hit),
        .fill       (fill),
        .rd_inst    (rd_inst)
    );

    icache_lru lru_i (
        .clk           (clk),
        .reset         (reset),
        .touch_valid   (touch_valid),
        .touch_index_a (touch_index_a),
        .touch_index_b (touch_index_b),
        .touch_way     (touch_way),
        .fill          (fill),
        .victim_way    (victim_way)
    );

endmodule

`default_nettype wire

// File: tb_icache_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache_mem
    import icache_pkg::*;
(
    input  logic  clk,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output logic  ret_valid,
    output line_t ret_data,
    input  logic  ucache_ren,
    input  addr_t ucache_addr,
    output logic  ucache_rvalid,
    output inst_t ucache_rdata,
    output int    refills
);

    integer seed;
    logic   busy;
    logic   uncached;
    addr_t  addr;
    int     count;

    function automatic line_t line_at(input addr_t base);
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i*INST_W +: INST_W] = (base + 32'(4 * i)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    initial begin
        seed          = 32'ha0fe214d;
        busy          = 1'b0;
        uncached      = 1'b0;
        addr          = '0;
        count         = 0;
        refills       = 0;
        ret_valid     = 1'b0;
        ret_data      = '0;
        ucache_rvalid = 1'b0;
        ucache_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;
            ret_valid     = 1'b0;  // pulses last one cycle
            ucache_rvalid = 1'b0;
            if (busy) begin
                if (count == 0) begin
                    busy = 1'b0;
                    if (uncached) begin
                        ucache_rvalid = 1'b1;
                        ucache_rdata  = ~addr;
                    end else begin
                        ret_valid = 1'b1;
                        ret_data  = line_at(addr);
                        refills   = refills + 1;
                    end
                end else begin
                    count = count - 1;
                end
            end else if (rd_req === 1'b1 || ucache_ren === 1'b1) begin
                busy     = 1'b1;
                uncached = rd_req !== 1'b1;
                addr     = uncached ? ucache_addr : rd_addr;
                count    = 1 + int'($unsigned($random(seed)) % 5);  // 2 to 6 cycles
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_icache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    localparam int TIMEOUT = 200;  // cycles per wait

    typedef struct packed {
        addr_t      pc;
        logic       uncache;
        logic [3:0] pause_cycles;
        logic       flush;
        logic [3:0] burst;  // back-to-back requests from pc on
        logic [1:0] exp_valid;
        logic [3:0] exp_refills;
    } row_t;

    logic        clk;
    logic        reset;
    logic        pause;
    logic        branch_flush;
    fetch_req_t  fetch_req;
    logic        stall;
    fetch_resp_t fetch_resp;
    logic        rd_req, ret_valid, ucache_ren, ucache_rvalid;
    addr_t       rd_addr, ucache_addr;
    line_t       ret_data;
    inst_t       ucache_rdata;
    int          refills;
    int          errors;
    int          checks;
    logic        timed_out;
    row_t        rows[$];

    icache_top icache_top_i (
        .clk           (clk),
        .reset         (reset),
        .pause         (pause),
        .branch_flush  (branch_flush),
        .fetch_req     (fetch_req),
        .stall         (stall),
        .fetch_resp    (fetch_resp),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .ret_valid     (ret_valid),
        .ret_data      (ret_data),
        .ucache_ren    (ucache_ren),
        .ucache_addr   (ucache_addr),
        .ucache_rvalid (ucache_rvalid),
        .ucache_rdata  (ucache_rdata)
    );

    tb_icache_mem mem_i (
        .clk           (clk),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .ret_valid     (ret_valid),
        .ret_data      (ret_data),
        .ucache_ren    (ucache_ren),
        .ucache_addr   (ucache_addr),
        .ucache_rvalid (ucache_rvalid),
        .ucache_rdata  (ucache_rdata),
        .refills       (refills)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic inst_t expected_word(input addr_t a, input logic uncache);
        return uncache ? ~a : a ^ 32'h5a5a0000;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic give_up(input string what);
        timed_out = 1'b1;
        $display("timeout at %0t: %s", $time, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input addr_t pc, input logic uncache, input int pause_cycles,
                           input logic flush, input int burst, input logic [1:0] exp_valid,
                           input int exp_refills);
        row_t r;
        r.pc           = pc;
        r.uncache      = uncache;
        r.pause_cycles = 4'(pause_cycles);
        r.flush        = flush;
        r.burst        = 4'(burst);
        r.exp_valid    = exp_valid;
        r.exp_refills  = 4'(exp_refills);
        rows.push_back(r);
    endtask

    task automatic drive_request(input addr_t pc, input logic uncache);
        fetch_req.valid   = 1'b1;
        fetch_req.pc      = pc;
        fetch_req.uncache = uncache;
    endtask

    task automatic wait_not_stalled();
        int waited;
        waited = 0;
        while (stall !== 1'b0 && !timed_out) begin
            waited++;
            if (waited > TIMEOUT) give_up("stall never dropped");
            else next_cycle();
        end
    endtask

    task automatic check_response(input row_t r, input int k);
        addr_t pc;
        pc = r.pc + 32'(4 * k);
        check_value("response valid", 32'(fetch_resp.valid), 32'(r.exp_valid));
        check_value("response pc", fetch_resp.pc, pc);
        check_value("slot 0 word", fetch_resp.inst[0], expected_word(pc, r.uncache));
        if (r.exp_valid[1]) begin
            check_value("slot 1 word", fetch_resp.inst[1], expected_word(pc + 32'd4, 1'b0));
        end
    endtask

    // response must sit still while paused
    task automatic hold_pause(input row_t r, input int k);
        pause = 1'b1;
        for (int i = 0; i < int'(r.pause_cycles); i++) begin
            next_cycle();
            check_response(r, k);
        end
        pause = 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int start_refills;
        int sent;
        int got;
        int waited;
        start_refills = refills;
        sent          = 0;
        got           = 0;
        waited        = 0;
        wait_not_stalled();
        if (timed_out) return;
        if (r.flush) begin
            drive_request(r.pc, r.uncache);
            next_cycle();
            fetch_req.valid = 1'b0;
            branch_flush    = 1'b1;  // one cycle after the request is taken
            next_cycle();
            branch_flush = 1'b0;
            for (int i = 0; i < 8; i++) begin
                check_value("valid after flush", 32'(fetch_resp.valid), 32'(r.exp_valid));
                next_cycle();
            end
        end else begin
            while (got < int'(r.burst) && !timed_out) begin
                if (fetch_resp.valid != 2'b00) begin
                    check_response(r, got);
                    if (r.pause_cycles != 0) hold_pause(r, got);
                    got++;
                end
                if (sent < int'(r.burst) && !stall) begin
                    drive_request(r.pc + 32'(4 * sent), r.uncache);
                    sent++;
                end else begin
                    fetch_req.valid = 1'b0;
                end
                if (got < int'(r.burst)) begin
                    waited++;
                    if (waited > TIMEOUT) give_up("no response from the cache");
                    else next_cycle();
                end
            end
            fetch_req.valid = 1'b0;
            next_cycle();  // let the last response drop
        end
        if (!timed_out) begin
            check_value("refill count", 32'(refills - start_refills), 32'(r.exp_refills));
        end
    endtask

    initial begin
        reset        = 1'b1;
        pause        = 1'b0;
        branch_flush = 1'b0;
        fetch_req    = '0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;

        add_row(32'h0000_2008, 1'b0, 0, 1'b0, 1, 2'b11, 1);  // cold miss
        add_row(32'h0000_2008, 1'b0, 0, 1'b0, 1, 2'b11, 0);
        add_row(32'h0000_2008, 1'b0, 0, 1'b0, 3, 2'b11, 0);  // back-to-back hits
        add_row(32'h0000_30fc, 1'b0, 0, 1'b0, 1, 2'b11, 2);  // word 7, two cold lines
        add_row(32'h0000_30fc, 1'b0, 0, 1'b0, 1, 2'b11, 0);
        add_row(32'h0001_0040, 1'b0, 0, 1'b0, 1, 2'b11, 1);  // A, B, C share set 2
        add_row(32'h0001_1040, 1'b0, 0, 1'b0, 1, 2'b11, 1);
        add_row(32'h0001_0040, 1'b0, 0, 1'b0, 1, 2'b11, 0);
        add_row(32'h0001_2040, 1'b0, 0, 1'b0, 1, 2'b11, 1);  // evicts B
        add_row(32'h0001_0040, 1'b0, 0, 1'b0, 1, 2'b11, 0);
        add_row(32'h0001_1040, 1'b0, 0, 1'b0, 1, 2'b11, 1);
        add_row(32'h1fc0_0010, 1'b1, 0, 1'b0, 1, 2'b01, 0);  // uncached
        add_row(32'h0000_2008, 1'b0, 4, 1'b0, 1, 2'b11, 0);
        add_row(32'h0000_2010, 1'b0, 0, 1'b1, 1, 2'b00, 0);
        add_row(32'h0000_200c, 1'b0, 0, 1'b0, 1, 2'b11, 0);

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (rows[i]) begin
            if (!timed_out) run_row(rows[i]);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
icache_pkg.sv
icache_ctrl.sv
icache_tagv.sv
icache_data.sv
icache_lru.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv

// File: Makefile
TOP = tb_icache

all: run

run: obj_dir/V$(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

obj_dir/V$(TOP): vlog.f *.sv
	verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
